// ==== logic/gelato_cfg_pkg.sv ====
// ##########################################################
// Instruction cache configuration
// Address, word and line sizes plus the cache address split
// ##########################################################

package gelato_cfg_pkg;

  // Byte address and instruction word
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // Line geometry
  localparam int LINE_WORDS = 4;
  localparam int LINE_W     = LINE_WORDS * DATA_W;
  localparam int LINE_NUM   = 16;

  // Address fields from the tag down to the byte offset
  localparam int OFFSET_W   = $clog2(LINE_W / 8);
  localparam int WORD_SEL_W = $clog2(LINE_WORDS);
  localparam int BYTE_SEL_W = OFFSET_W - WORD_SEL_W;
  localparam int INDEX_W    = $clog2(LINE_NUM);
  localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;

  // Core number width for the default build of four cores
  localparam int CORE_W = 2;

endpackage

// ==== logic/gelato_cache_pkg.sv ====
// ##########################################################
// Instruction cache types
// Fetch address views and the L1 line entry
// ##########################################################

package gelato_cache_pkg;

  // Fields of a fetch address
  typedef struct packed {
    logic [gelato_cfg_pkg::TAG_W-1:0]      tag;
    logic [gelato_cfg_pkg::INDEX_W-1:0]    index;
    logic [gelato_cfg_pkg::WORD_SEL_W-1:0] word;
    logic [gelato_cfg_pkg::BYTE_SEL_W-1:0] byte_off;
  } fetch_fields_t;

  // One address word, read raw for the bus or split for the cache
  typedef union packed {
    logic [gelato_cfg_pkg::ADDR_W-1:0] raw;
    fetch_fields_t                     f;
  } fetch_addr_u;

  // Cache line as an array of instruction words
  typedef logic [gelato_cfg_pkg::LINE_WORDS-1:0][gelato_cfg_pkg::DATA_W-1:0] l1_line_t;

  // One direct-mapped entry
  typedef struct packed {
    logic                             valid;
    logic [gelato_cfg_pkg::TAG_W-1:0] tag;
    l1_line_t                         line;
  } l1_entry_t;

endpackage

// ==== logic/gelato_l1_cache_if.sv ====
// ##########################################################
// Fetch link from the dispatcher to one L1 cache
// ##########################################################

`timescale 1ns/1ps

interface gelato_l1_cache_if;

  logic                              valid;
  logic [gelato_cfg_pkg::ADDR_W-1:0] addr;
  // One-cycle pulse with the fetched word
  logic                              done;
  logic [gelato_cfg_pkg::DATA_W-1:0] data;

  modport master (output valid, output addr, input done, input data);
  modport slave  (input valid, input addr, output done, output data);

endinterface

// ==== logic/gelato_l2_cache_if.sv ====
// ##########################################################
// Line fill link from one L1 cache to the miss arbiter
// ##########################################################

`timescale 1ns/1ps

interface gelato_l2_cache_if;

  // Request held until done, addr is line aligned
  logic                              valid;
  logic [gelato_cfg_pkg::ADDR_W-1:0] addr;
  logic                              done;
  logic [gelato_cfg_pkg::LINE_W-1:0] line;

  modport master (output valid, output addr, input done, input line);
  modport slave  (input valid, input addr, output done, output line);

endinterface

// ==== logic/gelato_fetch_dispatch.sv ====
// ##########################################################
// Fetch dispatcher
// Routes the shared fetch port to the per-core L1 caches
// and keeps one outstanding fetch per core
// ##########################################################

`timescale 1ns/1ps

module gelato_fetch_dispatch #(
  parameter  int NUM_CORES = 4,
  localparam int CORE_BITS = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              req_valid,
  input  logic [CORE_BITS-1:0]              req_core,
  input  logic [gelato_cfg_pkg::ADDR_W-1:0] req_addr,
  output logic                              req_ready,
  gelato_l1_cache_if.master                 l1 [NUM_CORES]
);

  logic [NUM_CORES-1:0] busy_vec;

  // Stall only the core that already has a fetch in flight
  assign req_ready = (int'(req_core) < NUM_CORES) && !busy_vec[req_core];

  for (genvar i = 0; i < NUM_CORES; i++) begin : g_core
    logic                              busy;
    logic                              valid_q;
    logic [gelato_cfg_pkg::ADDR_W-1:0] addr_q;
    logic                              take;

    assign take = req_valid && req_ready && (req_core == CORE_BITS'(i));

    // Accept marks busy, valid follows one cycle later
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        busy    <= 1'b0;
        valid_q <= 1'b0;
      end else if (take) begin
        busy <= 1'b1;
      end else if (l1[i].done) begin
        busy    <= 1'b0;
        valid_q <= 1'b0;
      end else if (busy) begin
        valid_q <= 1'b1;
      end
    end

    always_ff @(posedge clk) begin
      if (take) begin
        addr_q <= req_addr;
      end
    end

    assign busy_vec[i]  = busy;
    assign l1[i].valid = valid_q;
    assign l1[i].addr  = addr_q;
  end

endmodule

// ==== logic/gelato_l1_inst_cache.sv ====
// ##########################################################
// L1 instruction cache
// Direct-mapped, one per core, fills whole lines over the
// L2 link on a miss
// ##########################################################

`timescale 1ns/1ps

module gelato_l1_inst_cache (
  input  logic             clk,
  input  logic             rst_n,
  gelato_l1_cache_if.slave  fetch,
  gelato_l2_cache_if.master fill
);

  typedef enum logic {
    ST_IDLE,
    ST_FILL
  } state_e;

  state_e                             state;
  gelato_cache_pkg::l1_entry_t        entries [gelato_cfg_pkg::LINE_NUM];
  gelato_cache_pkg::fetch_addr_u      req;
  gelato_cache_pkg::l1_entry_t        cur;
  gelato_cache_pkg::l1_line_t         fill_line;
  logic                               hit;
  logic                               done_q;
  logic [gelato_cfg_pkg::DATA_W-1:0]  data_q;
  logic                               fill_valid;
  logic [gelato_cfg_pkg::ADDR_W-1:0]  fill_addr;

  // Decode the held fetch address
  assign req       = fetch.addr;
  assign cur       = entries[req.f.index];
  assign hit       = cur.valid && (cur.tag == req.f.tag);
  assign fill_line = fill.line;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= ST_IDLE;
      done_q     <= 1'b0;
      fill_valid <= 1'b0;
      for (int i = 0; i < gelato_cfg_pkg::LINE_NUM; i++) begin
        entries[i].valid <= 1'b0;
      end
    end else begin
      done_q <= 1'b0;
      case (state)
        ST_IDLE: begin
          // Skip the cycle where done is still out and valid not yet dropped
          if (fetch.valid && !done_q) begin
            if (hit) begin
              done_q <= 1'b1;
            end else begin
              fill_valid <= 1'b1;
              state      <= ST_FILL;
            end
          end
        end
        ST_FILL: begin
          if (fill.done) begin
            entries[req.f.index].valid <= 1'b1;
            entries[req.f.index].tag   <= req.f.tag;
            entries[req.f.index].line  <= fill_line;
            done_q     <= 1'b1;
            fill_valid <= 1'b0;
            state      <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // Word and fill address are only looked at alongside done and valid
  always_ff @(posedge clk) begin
    if (state == ST_FILL) begin
      data_q <= fill_line[req.f.word];
    end else begin
      data_q    <= cur.line[req.f.word];
      fill_addr <= {req.f.tag, req.f.index, {gelato_cfg_pkg::OFFSET_W{1'b0}}};
    end
  end

  assign fetch.done = done_q;
  assign fetch.data = data_q;
  assign fill.valid = fill_valid;
  assign fill.addr  = fill_addr;

endmodule

// ==== logic/gelato_l2_arbiter.sv ====
// ##########################################################
// Miss arbiter
// Round-robin over the L1 fill requests, each line read as
// four single Wishbone classic reads
// ##########################################################

`timescale 1ns/1ps

module gelato_l2_arbiter #(
  parameter  int NUM_CORES = 4,
  localparam int CORE_BITS = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1
) (
  input  logic                              clk,
  input  logic                              rst_n,
  gelato_l2_cache_if.slave                  fill [NUM_CORES],
  output logic                              wb_cyc,
  output logic                              wb_stb,
  output logic [gelato_cfg_pkg::ADDR_W-1:0] wb_adr,
  input  logic [gelato_cfg_pkg::DATA_W-1:0] wb_dat_i,
  input  logic                              wb_ack
);

  logic [NUM_CORES-1:0]                    req_vec;
  logic [gelato_cfg_pkg::ADDR_W-1:0]       addr_arr [NUM_CORES];
  logic [NUM_CORES-1:0]                    done_q;
  logic [CORE_BITS-1:0]                    ptr;
  logic [CORE_BITS-1:0]                    grant;
  logic [CORE_BITS-1:0]                    next_grant;
  logic                                    found;
  logic                                    active;
  logic [gelato_cfg_pkg::WORD_SEL_W-1:0]   beat;
  gelato_cache_pkg::l1_line_t              line_q;
  gelato_cache_pkg::fetch_addr_u           line_addr;
  gelato_cache_pkg::fetch_addr_u           bus_addr;

  for (genvar i = 0; i < NUM_CORES; i++) begin : g_port
    assign req_vec[i]   = fill[i].valid;
    assign addr_arr[i]  = fill[i].addr;
    assign fill[i].done = done_q[i];
    assign fill[i].line = line_q;
  end

  // First requester after the last core served
  always_comb begin
    int idx;
    next_grant = ptr;
    found      = 1'b0;
    for (int k = 1; k <= NUM_CORES; k++) begin
      idx = (int'(ptr) + k) % NUM_CORES;
      if (!found && req_vec[idx]) begin
        found      = 1'b1;
        next_grant = CORE_BITS'(idx);
      end
    end
  end

  // No grant in the done cycle, the served cache still shows valid then
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active <= 1'b0;
      done_q <= '0;
      ptr    <= CORE_BITS'(NUM_CORES - 1);
      grant  <= '0;
      beat   <= '0;
    end else begin
      done_q <= '0;
      if (!active) begin
        if (found && (done_q == '0)) begin
          active <= 1'b1;
          grant  <= next_grant;
          beat   <= '0;
        end
      end else if (wb_ack) begin
        beat <= beat + 1'b1;
        if (beat == '1) begin
          active        <= 1'b0;
          done_q[grant] <= 1'b1;
          ptr           <= grant;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!active) begin
      line_addr <= addr_arr[next_grant];
    end else if (wb_ack) begin
      line_q[beat] <= wb_dat_i;
    end
  end

  // Beat counter picks the word within the line
  always_comb begin
    bus_addr            = line_addr;
    bus_addr.f.word     = beat;
    bus_addr.f.byte_off = '0;
  end

  assign wb_cyc = active;
  assign wb_stb = active;
  assign wb_adr = bus_addr.raw;

endmodule

// ==== logic/gelato_icache_top.sv ====
// ##########################################################
// Instruction cache subsystem top
// Fetch dispatcher, per-core L1 caches and the Wishbone
// miss arbiter
// ##########################################################

`timescale 1ns/1ps

module gelato_icache_top #(
  parameter  int NUM_CORES = 1 << gelato_cfg_pkg::CORE_W,
  localparam int CORE_BITS = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1
) (
  input  logic                                             clk,
  input  logic                                             rst_n,
  // Shared fetch port
  input  logic                                             req_valid,
  input  logic [CORE_BITS-1:0]                             req_core,
  input  logic [gelato_cfg_pkg::ADDR_W-1:0]                req_addr,
  output logic                                             req_ready,
  // Per-core responses
  output logic [NUM_CORES-1:0]                             resp_done,
  output logic [NUM_CORES-1:0][gelato_cfg_pkg::DATA_W-1:0] resp_data,
  // Wishbone classic toward instruction memory
  output logic                                             wb_cyc,
  output logic                                             wb_stb,
  output logic [gelato_cfg_pkg::ADDR_W-1:0]                wb_adr,
  input  logic [gelato_cfg_pkg::DATA_W-1:0]                wb_dat_i,
  input  logic                                             wb_ack
);

  gelato_l1_cache_if l1_bus [NUM_CORES] ();
  gelato_l2_cache_if l2_bus [NUM_CORES] ();

  gelato_fetch_dispatch #(
    .NUM_CORES (NUM_CORES)
  ) u_dispatch (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_core  (req_core),
    .req_addr  (req_addr),
    .req_ready (req_ready),
    .l1        (l1_bus)
  );

  for (genvar i = 0; i < NUM_CORES; i++) begin : g_cache
    gelato_l1_inst_cache u_cache (
      .clk   (clk),
      .rst_n (rst_n),
      .fetch (l1_bus[i]),
      .fill  (l2_bus[i])
    );

    // Responses are seen where the dispatcher sees them
    assign resp_done[i] = l1_bus[i].done;
    assign resp_data[i] = l1_bus[i].data;
  end

  gelato_l2_arbiter #(
    .NUM_CORES (NUM_CORES)
  ) u_arbiter (
    .clk      (clk),
    .rst_n    (rst_n),
    .fill     (l2_bus),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_adr   (wb_adr),
    .wb_dat_i (wb_dat_i),
    .wb_ack   (wb_ack)
  );

endmodule

// ==== test/gelato_icache_tb.sv ====
// ##########################################################
// Instruction cache subsystem testbench
// Random fetches against a reference cache and a Wishbone
// memory with random wait states
// ##########################################################

`timescale 1ns/1ps

module gelato_icache_tb;

  localparam int NUM_TESTS   = 200;
  localparam int CYCLE_LIMIT = NUM_TESTS * 40;

  logic             clk;
  logic             rst_n;
  logic             req_valid;
  logic [1:0]       req_core;
  logic [31:0]      req_addr;
  logic             req_ready;
  logic [3:0]       resp_done;
  logic [3:0][31:0] resp_data;
  logic             wb_cyc;
  logic             wb_stb;
  logic [31:0]      wb_adr;
  logic [31:0]      wb_dat_i;
  logic             wb_ack;

  // Reference tags and valid bits for 16 lines per core
  bit          mvalid [4][16];
  int          mtag [4][16];
  logic [31:0] exp_addr [4];
  bit   [3:0]  exp_hit;
  bit   [3:0]  pending;
  int          acc_cyc [4];
  logic [31:0] rd_q [$];
  int          cyc_cnt;
  int          errors;
  int          failed_tests;
  int          misses;
  int          fills;
  int          rr_ptr = 3;
  int          wait_left;
  bit          slow;
  bit          cyc_prev;

  gelato_icache_top #(
    .NUM_CORES (4)
  ) UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_core  (req_core),
    .req_addr  (req_addr),
    .req_ready (req_ready),
    .resp_done (resp_done),
    .resp_data (resp_data),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_adr    (wb_adr),
    .wb_dat_i  (wb_dat_i),
    .wb_ack    (wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Memory word holds the inverted word index above the word index
  function automatic logic [31:0] mem_word(input logic [31:0] a);
    return {~a[17:2], a[17:2]};
  endfunction

  task automatic report_mismatch(input string sig, input logic [31:0] expv,
                                 input logic [31:0] actv);
    $display("[ERROR] %0t %s expected %0h got %0h", $time, sig, expv, actv);
    errors++;
  endtask

  task automatic end_test(input int n, input string name, input int err0);
    if (errors == err0) begin
      $display("Test %0d %s: pass", n, name);
    end else begin
      $display("Test %0d %s: fail", n, name);
      failed_tests++;
    end
  endtask

  // Four reads at consecutive words of the aligned line
  task automatic check_line_reads(input int start, input logic [31:0] addr);
    logic [31:0] base;
    base = {addr[31:4], 4'h0};
    for (int k = 0; k < 4; k++) begin
      if (rd_q[start+k] !== base + 32'(4 * k)) begin
        report_mismatch("wb_adr", base + 32'(4 * k), rd_q[start+k]);
      end
    end
  endtask

  // Predict hit or miss and hold the request until it is taken
  task automatic send_req(input int core, input logic [31:0] addr);
    int idx;
    idx = int'(addr[7:4]);
    exp_hit[core] = mvalid[core][idx] && (mtag[core][idx] == int'(addr[31:8]));
    if (!exp_hit[core]) begin
      mvalid[core][idx] = 1'b1;
      mtag[core][idx]   = int'(addr[31:8]);
      misses++;
    end
    exp_addr[core] = addr;
    pending[core]  = 1'b1;
    @(negedge clk);
    req_valid = 1'b1;
    req_core  = 2'(core);
    req_addr  = addr;
    #1;
    while (!req_ready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    req_valid     = 1'b0;
    acc_cyc[core] = cyc_cnt;
  endtask

  task automatic random_test(input int n);
    int          core;
    int          err0;
    int          rd0;
    logic [31:0] addr;
    core = int'($urandom_range(3, 0));
    addr = (32'($urandom_range(1, 0)) << 8) | (32'($urandom_range(3, 0)) << 4) |
           (32'($urandom_range(3, 0)) << 2);
    err0 = errors;
    rd0  = rd_q.size();
    send_req(core, addr);
    wait (pending[core] == 1'b0);
    if (exp_hit[core] && rd_q.size() != rd0) begin
      $display("Hit on core %0d at %0t started bus reads", core, $time);
      errors++;
    end else if (!exp_hit[core]) begin
      rr_ptr = core;
      if (rd_q.size() - rd0 != 4) begin
        report_mismatch("wishbone read count", 32'd4, 32'(rd_q.size() - rd0));
      end else begin
        check_line_reads(rd0, addr);
      end
    end
    end_test(n, "random fetch", err0);
  endtask

  // Core 0 misses on slow memory while core 1 hits
  task automatic stall_test(input int n);
    int err0;
    err0 = errors;
    send_req(1, 32'h0000_0000);
    wait (pending[1] == 1'b0);
    slow = 1'b1;
    send_req(0, 32'h0002_0000);
    send_req(1, 32'h0000_0004);
    wait (pending[1] == 1'b0);
    if (!pending[0]) begin
      $display("Miss on core 0 finished before the hit on core 1 at %0t", $time);
      errors++;
    end
    req_core = 2'd0;
    do begin
      #1;
      if (req_ready !== 1'b0) begin
        report_mismatch("req_ready", 32'd0, 32'(req_ready));
      end
      @(negedge clk);
    end while (!resp_done[0]);
    slow = 1'b0;
    wait (pending[0] == 1'b0);
    rr_ptr = 0;
    end_test(n, "miss from every core" == "" ? "" : "miss under slow ack", err0);
  endtask

  // One miss per core where the first issued is served alone
  task automatic all_miss_test(input int n);
    int          err0;
    int          rd0;
    int          ptr;
    int          c;
    int          order [4];
    bit   [3:0]  waiting;
    logic [31:0] a;
    err0 = errors;
    rd0  = rd_q.size();
    // The first miss is two past the last served core and the rest wrap around
    for (int k = 0; k < 4; k++) begin
      c = (rr_ptr + 2 + k) % 4;
      send_req(c, 32'h0001_0000 + (32'(c) << 8));
    end
    order[0] = (rr_ptr + 2) % 4;
    ptr      = order[0];
    waiting  = 4'b1111;
    waiting[ptr] = 1'b0;
    for (int m = 1; m < 4; m++) begin
      for (int k = 1; k <= 4; k++) begin
        c = (ptr + k) % 4;
        if (waiting[c]) begin
          order[m]   = c;
          waiting[c] = 1'b0;
          ptr        = c;
          break;
        end
      end
    end
    wait (pending == 4'b0000);
    if (rd_q.size() - rd0 != 16) begin
      report_mismatch("wishbone read count", 32'd16, 32'(rd_q.size() - rd0));
    end else begin
      for (int m = 0; m < 4; m++) begin
        a = rd_q[rd0+4*m];
        if (int'(a[9:8]) != order[m]) begin
          report_mismatch("served core", 32'(order[m]), 32'(a[9:8]));
        end
        check_line_reads(rd0 + 4 * m, 32'h0001_0000 + (32'(order[m]) << 8));
      end
    end
    rr_ptr = order[3];
    end_test(n, "miss from every core", err0);
  endtask

  // Wishbone memory with 0 to 3 wait states per read
  always @(negedge clk) begin
    if (wb_stb !== wb_cyc) begin
      report_mismatch("wb_stb", 32'(wb_cyc), 32'(wb_stb));
    end
    if (wb_cyc && !cyc_prev) begin
      fills++;
    end
    cyc_prev = wb_cyc;
    if (wb_ack) begin
      wb_ack = 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (wait_left > 0) begin
        wait_left--;
      end else begin
        wb_ack    = 1'b1;
        wb_dat_i  = mem_word(wb_adr);
        rd_q.push_back(wb_adr);
        wait_left = slow ? 12 : int'($urandom_range(3, 0));
      end
    end
  end

  // Response checks for every core
  always @(negedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (resp_done[i] === 1'b1) begin
        if (!pending[i]) begin
          $display("Response on core %0d at %0t with no fetch outstanding", i, $time);
          errors++;
        end else begin
          if (resp_data[i] !== mem_word(exp_addr[i])) begin
            report_mismatch($sformatf("resp_data[%0d]", i), mem_word(exp_addr[i]),
                            resp_data[i]);
          end
          if (exp_hit[i] && (cyc_cnt - acc_cyc[i] != 2)) begin
            report_mismatch($sformatf("hit latency core %0d", i), 32'd2,
                            32'(cyc_cnt - acc_cyc[i]));
          end
          pending[i] = 1'b0;
        end
      end
    end
  end

  always @(posedge clk) begin
    cyc_cnt++;
    if (cyc_cnt >= CYCLE_LIMIT) begin
      $display("Run stopped after %0d cycles without finishing", cyc_cnt);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial begin
    void'($urandom(83));
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req_core  = 2'd0;
    req_addr  = 32'd0;
    wb_dat_i  = 32'd0;
    wb_ack    = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    for (int t = 0; t < NUM_TESTS - 2; t++) begin
      random_test(t);
    end
    stall_test(NUM_TESTS - 2);
    all_miss_test(NUM_TESTS - 1);
    if (misses != fills) begin
      report_mismatch("line fill count", 32'(misses), 32'(fills));
    end
    $display("Tests: %0d  failed: %0d  errors: %0d", NUM_TESTS, failed_tests, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
logic/gelato_cfg_pkg.sv
logic/gelato_cache_pkg.sv
logic/gelato_l1_cache_if.sv
logic/gelato_l2_cache_if.sv
logic/gelato_fetch_dispatch.sv
logic/gelato_l1_inst_cache.sv
logic/gelato_l2_arbiter.sv
logic/gelato_icache_top.sv
test/gelato_icache_tb.sv

// ==== Makefile ====
TOP = gelato_icache_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f sim.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
